// ==== alu/alu.sv ====
// ALU with Y and Z registers
`default_nettype none

module alu
	import datapathPkg::*;
(
	input  wire logic              clock,
	input  wire logic              rst,
	input  wire logic              yIn,
	input  wire logic              zIn,
	input  wire aluOpT             aluOp,
	input  wire logic [WORD_W-1:0] busIn,
	output logic      [WORD_W-1:0] zData
);

	logic [WORD_W-1:0]  yReg;
	logic [WORD_W-1:0]  zReg;
	logic [WORD_W-1:0]  result;
	logic [SHAMT_W-1:0] shamt;

	assign shamt = busIn[SHAMT_W-1:0];  // Shift count from bus

	// Y holds the first operand
	always_ff @(posedge clock) begin
		if (rst) begin
			yReg <= '0;
		end else if (yIn) begin
			yReg <= busIn;
		end
	end

	always_comb begin
		case (aluOp)
			ADD:     result = yReg + busIn;
			SUB:     result = yReg - busIn;
			AND:     result = yReg & busIn;
			OR:      result = yReg | busIn;
			SHR:     result = yReg >> shamt;
			SHRA:    result = WORD_W'($signed(yReg) >>> shamt);
			SHL:     result = yReg << shamt;
			NEG:     result = -busIn;      // Two's complement of bus
			NOT:     result = ~busIn;
			INC:     result = busIn + 1'b1;
			default: result = busIn;       // NOP
		endcase
	end

	// Result register, readable next step
	always_ff @(posedge clock) begin
		if (rst) begin
			zReg <= '0;
		end else if (zIn) begin
			zReg <= result;
		end
	end

	assign zData = zReg;

endmodule

`default_nettype wire

// ==== common/datapathPkg.sv ====
// Datapath shared definitions
`default_nettype none

package datapathPkg;

	// Word and bus width
	localparam int WORD_W = 32;

	// General register file
	localparam int REG_COUNT = 16;
	localparam int REG_IDX_W = 4;

	// Main memory, addressed by the low bits of MAR
	localparam int MEM_DEPTH  = 512;
	localparam int MEM_ADDR_W = 9;

	// Instruction fields, packed from the top of the word downward
	localparam int OPCODE_MSB = WORD_W - 1;          // Bit 31
	localparam int OPCODE_LSB = OPCODE_MSB - 4;      // Bit 27
	localparam int RA_MSB     = OPCODE_LSB - 1;      // ra at 26..23
	localparam int RB_MSB     = RA_MSB - REG_IDX_W;  // rb at 22..19
	localparam int RC_MSB     = RB_MSB - REG_IDX_W;  // rc at 18..15

	// Constant field fills everything below rb
	localparam int CONST_W = RC_MSB + 1;             // 19 bits

	// ALU operation select
	typedef enum logic [3:0] {
		NOP  = 4'd0,  // Pass bus through
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		SHR  = 4'd5,
		SHRA = 4'd6,
		SHL  = 4'd7,
		NEG  = 4'd8,
		NOT  = 4'd9,
		INC  = 4'd10  // Bus plus one, Y ignored
	} aluOpT;

	// Shift amount taken from the bus
	localparam int SHAMT_W = 5;

endpackage

`default_nettype wire

// ==== datapath.f ====
+incdir+verif
common/datapathPkg.sv
regfile/registerFile.sv
alu/alu.sv
logic/instructionUnit.sv
logic/memoryUnit.sv
logic/busMux.sv
logic/datapath.sv
verif/datapathTb.sv

// ==== logic/busMux.sv ====
// Shared bus source select
`default_nettype none

module busMux
	import datapathPkg::*;
(
	input  wire logic              regOut,
	input  wire logic              pcOut,
	input  wire logic              mdrOut,
	input  wire logic              zOut,
	input  wire logic              cOut,
	input  wire logic              inPortOut,
	input  wire logic [WORD_W-1:0] regData,
	input  wire logic [WORD_W-1:0] pcData,
	input  wire logic [WORD_W-1:0] mdrData,
	input  wire logic [WORD_W-1:0] zData,
	input  wire logic [WORD_W-1:0] constData,
	input  wire logic [WORD_W-1:0] inPortData,
	output logic      [WORD_W-1:0] busValue
);

	logic [2:0] sel;

	// Priority encode of drive strobes
	always_comb begin
		if (regOut)         sel = 3'd1;
		else if (pcOut)     sel = 3'd2;
		else if (mdrOut)    sel = 3'd3;
		else if (zOut)      sel = 3'd4;
		else if (cOut)      sel = 3'd5;
		else if (inPortOut) sel = 3'd6;
		else                sel = 3'd0;   // Bus idle
	end

	always_comb begin
		case (sel)
			3'd1:    busValue = regData;
			3'd2:    busValue = pcData;
			3'd3:    busValue = mdrData;
			3'd4:    busValue = zData;
			3'd5:    busValue = constData;  // Sign-extended constant
			3'd6:    busValue = inPortData;
			default: busValue = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/datapath.sv ====
// Single-bus datapath top
`default_nettype none

module datapath
	import datapathPkg::*;
(
	input  wire logic              clock,
	input  wire logic              rst,
	// Bus drive strobes
	input  wire logic              regOut,
	input  wire logic              pcOut,
	input  wire logic              mdrOut,
	input  wire logic              zOut,
	input  wire logic              cOut,
	input  wire logic              inPortOut,
	// Register select
	input  wire logic              gra,
	input  wire logic              grb,
	input  wire logic              grc,
	input  wire logic              baOut,
	// Memory control
	input  wire logic              mdMuxRead,
	input  wire logic              ramRead,
	input  wire logic              ramWrite,
	// Load enables
	input  wire logic              regIn,
	input  wire logic              pcIn,
	input  wire logic              irIn,
	input  wire logic              yIn,
	input  wire logic              zIn,
	input  wire logic              marIn,
	input  wire logic              mdrIn,
	input  wire logic              outPortIn,
	input  wire aluOpT             aluOp,
	input  wire logic [WORD_W-1:0] inPortData,
	output logic      [WORD_W-1:0] outPortData
);

	logic [WORD_W-1:0]    busValue;
	logic [WORD_W-1:0]    regData;
	logic [WORD_W-1:0]    pcData;
	logic [WORD_W-1:0]    mdrData;
	logic [WORD_W-1:0]    zData;
	logic [WORD_W-1:0]    constData;
	logic [REG_IDX_W-1:0] regIdx;
	logic [WORD_W-1:0]    outPortReg;

	registerFile regFile_inst (
		.clock, .rst, .regIn, .baOut, .regIdx,
		.busIn(busValue), .regData
	);

	alu alu_inst (
		.clock, .rst, .yIn, .zIn, .aluOp,
		.busIn(busValue), .zData
	);

	instructionUnit instrUnit_inst (
		.clock, .rst, .pcIn, .irIn, .gra, .grb, .grc,
		.busIn(busValue), .pcData, .regIdx, .constData
	);

	memoryUnit memUnit_inst (
		.clock, .rst, .marIn, .mdrIn, .mdMuxRead, .ramRead, .ramWrite,
		.busIn(busValue), .mdrData
	);

	busMux busMux_inst (
		.regOut, .pcOut, .mdrOut, .zOut, .cOut, .inPortOut,
		.regData, .pcData, .mdrData, .zData, .constData, .inPortData,
		.busValue
	);

	// Output port latches the bus at end of step
	always_ff @(posedge clock) begin
		if (rst) begin
			outPortReg <= '0;
		end else if (outPortIn) begin
			outPortReg <= busValue;
		end
	end

	assign outPortData = outPortReg;

endmodule

`default_nettype wire

// ==== logic/instructionUnit.sv ====
// PC, IR and field decode
`default_nettype none

module instructionUnit
	import datapathPkg::*;
(
	input  wire logic                 clock,
	input  wire logic                 rst,
	input  wire logic                 pcIn,
	input  wire logic                 irIn,
	input  wire logic                 gra,
	input  wire logic                 grb,
	input  wire logic                 grc,
	input  wire logic [WORD_W-1:0]    busIn,
	output logic      [WORD_W-1:0]    pcData,
	output logic      [REG_IDX_W-1:0] regIdx,
	output logic      [WORD_W-1:0]    constData
);

	logic [WORD_W-1:0] pcReg;
	logic [WORD_W-1:0] irReg;

	always_ff @(posedge clock) begin
		if (rst) begin
			pcReg <= '0;
			irReg <= '0;
		end else begin
			if (pcIn) pcReg <= busIn;
			if (irIn) irReg <= busIn;
		end
	end

	assign pcData = pcReg;

	// Register field select, gra first
	always_comb begin
		if (gra) begin
			regIdx = irReg[RA_MSB -: REG_IDX_W];
		end else if (grb) begin
			regIdx = irReg[RB_MSB -: REG_IDX_W];
		end else if (grc) begin
			regIdx = irReg[RC_MSB -: REG_IDX_W];
		end else begin
			regIdx = '0;
		end
	end

	// Sign-extend the low constant field
	assign constData = {{(WORD_W - CONST_W){irReg[CONST_W-1]}}, irReg[CONST_W-1:0]};

endmodule

`default_nettype wire

// ==== logic/memoryUnit.sv ====
// MAR, MDR and RAM
`default_nettype none

module memoryUnit
	import datapathPkg::*;
(
	input  wire logic              clock,
	input  wire logic              rst,
	input  wire logic              marIn,
	input  wire logic              mdrIn,
	input  wire logic              mdMuxRead,  // Select RAM data into MDR
	input  wire logic              ramRead,
	input  wire logic              ramWrite,
	input  wire logic [WORD_W-1:0] busIn,
	output logic      [WORD_W-1:0] mdrData
);

	logic [MEM_ADDR_W-1:0] marReg;   // Only the address bits are kept
	logic [WORD_W-1:0]     mdrReg;
	logic [WORD_W-1:0]     mdrNext;
	logic [WORD_W-1:0]     ramData;
	logic [WORD_W-1:0]     ram [MEM_DEPTH];

	always_ff @(posedge clock) begin
		if (rst) begin
			marReg <= '0;
		end else if (marIn) begin
			marReg <= busIn[MEM_ADDR_W-1:0];
		end
	end

	// Asynchronous read at MAR
	assign ramData = ram[marReg];

	// MDR input multiplexer
	always_comb begin
		if (mdMuxRead && ramRead) begin
			mdrNext = ramData;
		end else begin
			mdrNext = busIn;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			mdrReg <= '0;
		end else if (mdrIn) begin
			mdrReg <= mdrNext;
		end
	end

	// Memory write from MDR
	always_ff @(posedge clock) begin
		if (ramWrite) begin
			ram[marReg] <= mdrReg;
		end
	end

	assign mdrData = mdrReg;

endmodule

`default_nettype wire

// ==== regfile/registerFile.sv ====
// General register file
`default_nettype none

module registerFile
	import datapathPkg::*;
(
	input  wire logic                 clock,
	input  wire logic                 rst,
	input  wire logic                 regIn,   // Write strobe
	input  wire logic                 baOut,   // Base-address read mode
	input  wire logic [REG_IDX_W-1:0] regIdx,
	input  wire logic [WORD_W-1:0]    busIn,
	output logic      [WORD_W-1:0]    regData
);

	logic [WORD_W-1:0] regs [REG_COUNT];

	// Write port
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regIn) begin
			regs[regIdx] <= busIn;
		end
	end

	// R0 reads as zero only when used as a base
	always_comb begin
		if (baOut && (regIdx == '0)) begin
			regData = '0;
		end else begin
			regData = regs[regIdx];
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
TOP=datapathTb

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -f datapath.f; then
	echo "Verilator compilation failed"
	exit 1
fi

if ! "./$BUILD_DIR/V$TOP"; then
	echo "Simulation ended with an error"
	exit 1
fi

exit 0

// ==== verif/controlSteps.svh ====
// Control-step stimulus table
`ifndef CONTROL_STEPS_SVH
`define CONTROL_STEPS_SVH

localparam int CTL_W = 21;

// One-hot strobe masks ORed together into a control word
typedef enum logic [CTL_W-1:0] {
	REG_OUT     = 21'h000001, PC_OUT    = 21'h000002, MDR_OUT     = 21'h000004,
	Z_OUT       = 21'h000008, C_OUT     = 21'h000010, IN_PORT_OUT = 21'h000020,
	GRA         = 21'h000040, GRB       = 21'h000080, GRC         = 21'h000100,
	BA_OUT      = 21'h000200, MD_MUX_READ = 21'h000400, RAM_READ  = 21'h000800,
	RAM_WRITE   = 21'h001000, REG_IN    = 21'h002000, PC_IN       = 21'h004000,
	IR_IN       = 21'h008000, Y_IN      = 21'h010000, Z_IN        = 21'h020000,
	MAR_IN      = 21'h040000, MDR_IN    = 21'h080000, OUT_PORT_IN = 21'h100000
} ctlMaskT;

// Row fields are control word, ALU op, input port, expected output port and check flag
typedef struct packed {
	logic [CTL_W-1:0]  ctl;
	aluOpT             op;
	logic [WORD_W-1:0] inData;
	logic [WORD_W-1:0] expData;
	logic              check;
} stepT;

stepT steps[$];

task automatic addStep(input logic [CTL_W-1:0] ctl, input aluOpT op,
		input logic [WORD_W-1:0] inData);
	steps.push_back(stepT'{ctl, op, inData, 32'h0, 1'b0});
endtask

// Output port checked one cycle after this row
task automatic addCheckedStep(input logic [CTL_W-1:0] ctl, input logic [WORD_W-1:0] expData);
	steps.push_back(stepT'{ctl, NOP, 32'h0, expData, 1'b1});
endtask

// Fetch and execute ldi in steps T0 to T5
task automatic addLdiSteps();
	addStep(PC_OUT | MAR_IN | Z_IN, INC, '0);                       // T0
	addStep(Z_OUT | PC_IN | RAM_READ | MD_MUX_READ | MDR_IN, NOP, '0);
	addStep(MDR_OUT | IR_IN, NOP, '0);
	addStep(GRB | BA_OUT | REG_OUT | Y_IN, NOP, '0);                // Base into Y
	addStep(C_OUT | Z_IN, ADD, '0);
	addStep(Z_OUT | GRA | REG_IN, NOP, '0);                         // T5
endtask

// Y op R0 into R4, seen on the port as it is written
task automatic addAluOp(input aluOpT op, input logic [WORD_W-1:0] expData);
	addStep(GRB | REG_OUT | Z_IN, op, '0);
	addCheckedStep(Z_OUT | GRC | REG_IN | OUT_PORT_IN, expData);
endtask

task automatic loadSteps();
	addCheckedStep(PC_OUT | OUT_PORT_IN, 32'h0000_0000);          // PC cleared by reset
	addStep(PC_OUT | Z_IN, INC, '0);
	addStep(Z_OUT | PC_IN, NOP, '0);
	addCheckedStep(PC_OUT | OUT_PORT_IN, 32'h0000_0001);
	// Three ldi words at addresses 1 to 3
	addStep(IN_PORT_OUT | MAR_IN, NOP, 32'd1);
	addStep(IN_PORT_OUT | MDR_IN, NOP, 32'h2900_0095);            // ldi R2,0x95
	addStep(RAM_WRITE | IN_PORT_OUT | MAR_IN, NOP, 32'd2);
	addStep(IN_PORT_OUT | MDR_IN, NOP, 32'h2810_0038);            // ldi R0,0x38(R2)
	addStep(RAM_WRITE | IN_PORT_OUT | MAR_IN, NOP, 32'd3);
	addStep(IN_PORT_OUT | MDR_IN, NOP, 32'h2997_FFFF);            // ldi R3,-1(R2)
	addStep(RAM_WRITE | IN_PORT_OUT | MAR_IN, NOP, 32'd1);        // Last write with MAR back to 1
	addStep(RAM_READ | MD_MUX_READ | MDR_IN, NOP, '0);
	addCheckedStep(MDR_OUT | OUT_PORT_IN, 32'h2900_0095);
	addLdiSteps();
	addCheckedStep(GRA | REG_OUT | OUT_PORT_IN, 32'h0000_0095);
	addLdiSteps();
	addCheckedStep(GRA | REG_OUT | OUT_PORT_IN, 32'h0000_00CD);
	addLdiSteps();
	addCheckedStep(GRA | REG_OUT | OUT_PORT_IN, 32'h0000_0094);   // Sign-extended -1
	// ra R2, rb R0, rc R4
	addStep(IN_PORT_OUT | IR_IN, NOP, 32'h0102_0000);
	addCheckedStep(GRB | BA_OUT | REG_OUT | OUT_PORT_IN, 32'h0000_0000);  // R0 as base reads zero
	addStep(GRA | REG_OUT | Y_IN, NOP, '0);
	addAluOp(ADD, 32'h0000_0162);
	addAluOp(SUB, 32'hFFFF_FFC8);
	addAluOp(AND, 32'h0000_0085);
	addAluOp(OR, 32'h0000_00DD);
	addAluOp(NEG, 32'hFFFF_FF33);
	addAluOp(NOT, 32'hFFFF_FF32);
	addStep(GRC | REG_OUT | Y_IN, NOP, '0);                         // Negative Y for shifts
	addAluOp(SHL, 32'hFFE6_4000);                                  // Shift count 13
	addAluOp(SHR, 32'h0007_FFFF);
	addAluOp(SHRA, 32'hFFFF_FFFF);
	addCheckedStep(GRC | REG_OUT | OUT_PORT_IN, 32'hFFFF_FFFF);
endtask

`endif

// ==== verif/datapathTb.sv ====
// Datapath control-step testbench
`default_nettype none

module datapathTb
	import datapathPkg::*;
();

	`include "controlSteps.svh"

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 1;
	localparam int MAX_TIME     = 2000;

	logic              clock;
	logic              rst;
	logic [CTL_W-1:0]  ctl;
	aluOpT             aluOp;
	logic [WORD_W-1:0] inPortData;
	logic [WORD_W-1:0] outPortData;

	datapath datapath_inst (
		.clock, .rst,
		.regOut(|(ctl & REG_OUT)), .pcOut(|(ctl & PC_OUT)),
		.mdrOut(|(ctl & MDR_OUT)), .zOut(|(ctl & Z_OUT)),
		.cOut(|(ctl & C_OUT)), .inPortOut(|(ctl & IN_PORT_OUT)),
		.gra(|(ctl & GRA)), .grb(|(ctl & GRB)), .grc(|(ctl & GRC)),
		.baOut(|(ctl & BA_OUT)), .mdMuxRead(|(ctl & MD_MUX_READ)),
		.ramRead(|(ctl & RAM_READ)), .ramWrite(|(ctl & RAM_WRITE)),
		.regIn(|(ctl & REG_IN)), .pcIn(|(ctl & PC_IN)), .irIn(|(ctl & IR_IN)),
		.yIn(|(ctl & Y_IN)), .zIn(|(ctl & Z_IN)), .marIn(|(ctl & MAR_IN)),
		.mdrIn(|(ctl & MDR_IN)), .outPortIn(|(ctl & OUT_PORT_IN)),
		.aluOp, .inPortData, .outPortData
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Watchdog on the whole run
	initial begin
		#(MAX_TIME);
		$display("Timeout: the control-step table did not complete in time");
		$display("RESULT: FAIL");
		$fatal(1, "Simulation timed out");
	end

	task automatic checkOutput(input int row, input logic [WORD_W-1:0] expData);
		assert (outPortData == expData) else begin
			$display("FAILED at time %0t: row %0d output port %h, expected %h",
				$time, row, outPortData, expData);
			$display("RESULT: FAIL");
			$fatal(1, "Output port mismatch");
		end
	endtask

	task automatic applyStep(input stepT s);
		ctl        = s.ctl;
		aluOp      = s.op;
		inPortData = s.inData;
	endtask

	initial begin
		logic              havePending;
		logic [WORD_W-1:0] pendingExp;
		int                pendingRow;
		ctl         = '0;
		aluOp       = NOP;
		inPortData  = '0;
		rst         = 1'b1;
		havePending = 1'b0;
		pendingExp  = '0;
		pendingRow  = 0;
		loadSteps();
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge clock);
		end
		#(DRIVE_DELAY);
		rst = 1'b0;
		// One row per cycle, checking the previous flagged row first
		for (int r = 0; r < steps.size(); r++) begin
			if (r > 0) begin
				@(posedge clock);
				#(DRIVE_DELAY);
			end
			if (havePending) begin
				checkOutput(pendingRow, pendingExp);
			end
			applyStep(steps[r]);
			havePending = steps[r].check;
			pendingExp  = steps[r].expData;
			pendingRow  = r;
		end
		@(posedge clock);
		#(DRIVE_DELAY);
		if (havePending) begin
			checkOutput(pendingRow, pendingExp);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
